/* addrgen_top.f */
hdl/addrgen_pkg.sv
hdl/addrgen_req_stage.sv
hdl/addrgen_burst_plan.sv
hdl/addrgen_axi_issue.sv
hdl/addrgen_cmd_queue.sv
hdl/addrgen_top.sv
bench/addrgen_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the address generator testbench with Verilator and run it
# A $fatal in the testbench gives a non-zero exit status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module addrgen_tb -f addrgen_top.f -o addrgen_sim \
  && ./obj_dir/addrgen_sim \
  || { echo "run_sim.sh: build or simulation returned an error"; exit 1; }

/* bench/addrgen_trace.txt */
# R name access(0 unit, 1 strided) is_load addr(hex) len vew(log2 bytes) stride(hex) error
# B addr(hex) axlen(hex) axsize is_load, one line per expected transaction of the request above
R unit_load_ew32     0 1 00001000 16  2 00000000 0
B 00001000 07 3 1
R page_cross_store   0 0 00002ff0 8   3 00000000 0
B 00002ff0 01 3 0
B 00003000 05 3 0
R long_load_split    0 1 00004000 300 3 00000000 0
B 00004000 ff 3 1
B 00004800 2b 3 1
R beat_offset_load   0 1 00005006 5   1 00000000 0
B 00005006 01 3 1
R partial_beat_store 0 0 00006000 3   2 00000000 0
B 00006000 01 3 0
R misalign_ew32      0 1 00001002 16  2 00000000 1
R neg_stride_load    1 1 00008010 4   1 fffffffa 0
B 00008010 00 1 1
B 0000800a 00 1 1
B 00008004 00 1 1
B 00007ffe 00 1 1
R stride_store_ew64  1 0 00009000 3   3 00000100 0
B 00009000 00 3 0
B 00009100 00 3 0
B 00009200 00 3 0
R misalign_ew64      1 0 0000a004 2   3 00000008 1
R unit_load_ew8      0 1 0000b003 9   0 00000000 0
B 0000b003 01 3 1

/* bench/addrgen_tb.sv */
//////////////////////////////
// Address generator testbench
// Replays the request trace under random AXI and LSU
// back-pressure and checks every transaction and command
//////////////////////////////

`timescale 1ns/100ps

module addrgen_tb;

  localparam int MaxReqs       = 32;
  localparam int MaxTxns       = 64;
  localparam int QueueSlots    = 4;
  // Cycle budget per trace line
  localparam int CyclesPerLine = 40;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_valid_i;
  addrgen_pkg::access_e req_access_i;
  logic                 req_is_load_i;
  addrgen_pkg::addr_t   req_addr_i;
  addrgen_pkg::vlen_t   req_len_i;
  addrgen_pkg::vew_e    req_vew_i;
  addrgen_pkg::stride_t req_stride_i;
  logic                 ack_o;
  logic                 error_o;
  logic                 axi_ar_valid_o;
  logic                 axi_ar_ready_i;
  addrgen_pkg::addr_t   axi_ar_addr_o;
  addrgen_pkg::axlen_t  axi_ar_len_o;
  addrgen_pkg::axsize_t axi_ar_size_o;
  logic                 axi_aw_valid_o;
  logic                 axi_aw_ready_i;
  addrgen_pkg::addr_t   axi_aw_addr_o;
  addrgen_pkg::axlen_t  axi_aw_len_o;
  addrgen_pkg::axsize_t axi_aw_size_o;
  logic                 lsu_valid_o;
  logic                 lsu_ready_i;
  addrgen_pkg::addr_t   lsu_addr_o;
  addrgen_pkg::axlen_t  lsu_len_o;
  addrgen_pkg::axsize_t lsu_size_o;
  logic                 lsu_is_load_o;

  //////////////////////////////
  // Trace contents
  //////////////////////////////

  logic [8*24-1:0] req_name   [MaxReqs];
  int              req_acc    [MaxReqs];
  int              req_ld     [MaxReqs];
  logic [31:0]     req_addr   [MaxReqs];
  int              req_len    [MaxReqs];
  int              req_vew    [MaxReqs];
  logic [31:0]     req_stride [MaxReqs];
  int              req_err    [MaxReqs];
  // First expected transaction and how many belong to the request
  int              req_first  [MaxReqs];
  int              req_count  [MaxReqs];
  logic [31:0]     txn_addr   [MaxTxns];
  int              txn_len    [MaxTxns];
  int              txn_size   [MaxTxns];
  int              txn_ld     [MaxTxns];
  int              txn_req    [MaxTxns];
  int              num_reqs;
  int              num_txns;
  int              trace_lines;

  // Expected order on the AXI channels and at the LSU side
  int              axi_q [$];
  int              lsu_q [$];
  // Commands held in the DUT queue per the handshakes seen
  int              queued;
  // Expected direction at the queue head, -1 when empty
  int              head_ld;
  int              idx;
  logic            handshake;
  logic            pop;
  // AXI request still waiting for its ready at the last sample
  logic            ar_wait;
  logic            aw_wait;
  logic [31:0]     wait_addr;
  logic [31:0]     wait_len;
  logic [31:0]     wait_size;
  logic            waiting_ack;
  logic [8*24-1:0] cur_name;
  int              cycles;
  int              limit;
  int              seed;

  addrgen_top DUT (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%0s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input logic [8*24-1:0] test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %0s %0s expected %h actual %h", test, what, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_txn(input int t, input string chan, input logic [31:0] addr,
                             input logic [31:0] len, input logic [31:0] size,
                             input logic [31:0] ld);
    logic [8*24-1:0] test;
    test = req_name[txn_req[t]];
    compare_value(test, {chan, " addr"}, txn_addr[t], addr);
    compare_value(test, {chan, " len"}, 32'(txn_len[t]), len);
    compare_value(test, {chan, " size"}, 32'(txn_size[t]), size);
    compare_value(test, {chan, " is_load"}, 32'(txn_ld[t]), ld);
  endtask

  task automatic load_trace;
    int              fd;
    int              code;
    int              n;
    string           line;
    logic [8*24-1:0] name;
    int              acc;
    int              ld;
    int              len;
    int              vew;
    int              err;
    int              size;
    logic [31:0]     addr;
    logic [31:0]     stride;
    fd = $fopen("bench/addrgen_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the trace file bench/addrgen_trace.txt");
    end
    while (fd != 0 && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.getc(0) == "R") begin
        n = $sscanf(line, "R %s %d %d %h %d %d %h %d",
                    name, acc, ld, addr, len, vew, stride, err);
        if (n != 8 || num_reqs == MaxReqs) begin
          abort_run("Request line in the trace is malformed or beyond the table size");
        end else begin
          req_name[num_reqs]   = name;
          req_acc[num_reqs]    = acc;
          req_ld[num_reqs]     = ld;
          req_addr[num_reqs]   = addr;
          req_len[num_reqs]    = len;
          req_vew[num_reqs]    = vew;
          req_stride[num_reqs] = stride;
          req_err[num_reqs]    = err;
          req_first[num_reqs]  = num_txns;
          req_count[num_reqs]  = 0;
          num_reqs++;
          trace_lines++;
        end
      end else if (code > 0 && line.getc(0) == "B") begin
        n = $sscanf(line, "B %h %h %d %d", addr, len, size, ld);
        if (n != 4 || num_reqs == 0 || num_txns == MaxTxns) begin
          abort_run("Transaction line in the trace is malformed or has no request");
        end else begin
          txn_addr[num_txns] = addr;
          txn_len[num_txns]  = len;
          txn_size[num_txns] = size;
          txn_ld[num_txns]   = ld;
          txn_req[num_txns]  = num_reqs - 1;
          req_count[num_reqs-1]++;
          num_txns++;
          trace_lines++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Drive one request and hold it until the ack
  task automatic run_request(input int r);
    logic got_ack;
    got_ack = 1'b0;
    @(posedge clk_i);
    cur_name      = req_name[r];
    waiting_ack   = 1'b1;
    req_valid_i   <= 1'b1;
    req_access_i  <= addrgen_pkg::access_e'(req_acc[r]);
    req_is_load_i <= (req_ld[r] != 0);
    req_addr_i    <= req_addr[r];
    req_len_i     <= addrgen_pkg::vlen_t'(req_len[r]);
    req_vew_i     <= addrgen_pkg::vew_e'(req_vew[r]);
    req_stride_i  <= req_stride[r];
    for (int t = req_first[r]; t < req_first[r] + req_count[r]; t++) begin
      axi_q.push_back(t);
      lsu_q.push_back(t);
    end
    while (!got_ack) begin
      @(negedge clk_i);
      got_ack = ack_o;
    end
    compare_value(cur_name, "error_o", 32'(req_err[r]), 32'(error_o));
    // Done follows the last handshake so nothing may be left
    compare_value(cur_name, "AXI left at ack", 32'd0, 32'(axi_q.size()));
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    waiting_ack = 1'b0;
  endtask

  // Random ready on AR, AW and the LSU side
  // High three times in four
  always @(posedge clk_i) begin
    axi_ar_ready_i <= (($random(seed) & 3) != 0);
    axi_aw_ready_i <= (($random(seed) & 3) != 0);
    lsu_ready_i    <= (($random(seed) & 3) != 0);
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      abort_run("Timeout, the trace did not complete within the cycle limit");
    end
  end

  //////////////////////////////
  // Monitor sampled mid-cycle
  //////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      handshake = (axi_ar_valid_o && axi_ar_ready_i) || (axi_aw_valid_o && axi_aw_ready_i);
      pop       = lsu_valid_o && lsu_ready_i;
      // Queue holds the oldest issued commands in trace order
      head_ld   = -1;
      if (queued != 0) begin
        head_ld = txn_ld[lsu_q[0]];
      end
      if (error_o && !ack_o) begin
        abort_run("error_o pulsed without ack_o");
      end else if (ack_o && !waiting_ack) begin
        abort_run("ack_o pulsed with no request outstanding");
      end else if (axi_ar_valid_o && axi_aw_valid_o) begin
        abort_run("AR and AW valid in the same cycle");
      end else if ((ar_wait && !axi_ar_valid_o) || (aw_wait && !axi_aw_valid_o)) begin
        abort_run("AXI valid dropped before its ready was seen");
      end else if (axi_aw_valid_o && head_ld == 1) begin
        abort_run("Store offered on AW while a load command heads the queue");
      end else if (axi_ar_valid_o && head_ld == 0) begin
        abort_run("Load offered on AR while a store command heads the queue");
      end else if ((axi_ar_valid_o || axi_aw_valid_o) && queued == QueueSlots) begin
        abort_run("Transaction offered while the command queue is full");
      end else if (handshake && axi_q.size() == 0) begin
        abort_run("AXI handshake that the trace does not expect");
      end else if (pop && lsu_q.size() == 0) begin
        abort_run("LSU command that the trace does not expect");
      end else begin
        compare_value(cur_name, "lsu_valid_o", 32'(queued != 0), 32'(lsu_valid_o));
        // Fields stay put while the channel waits for ready
        if (ar_wait) begin
          compare_value(cur_name, "AR addr held", wait_addr, axi_ar_addr_o);
          compare_value(cur_name, "AR len held", wait_len, 32'(axi_ar_len_o));
          compare_value(cur_name, "AR size held", wait_size, 32'(axi_ar_size_o));
        end
        if (aw_wait) begin
          compare_value(cur_name, "AW addr held", wait_addr, axi_aw_addr_o);
          compare_value(cur_name, "AW len held", wait_len, 32'(axi_aw_len_o));
          compare_value(cur_name, "AW size held", wait_size, 32'(axi_aw_size_o));
        end
        if (axi_ar_valid_o && axi_ar_ready_i) begin
          idx = axi_q.pop_front();
          compare_txn(idx, "AR", axi_ar_addr_o, 32'(axi_ar_len_o), 32'(axi_ar_size_o), 32'd1);
        end
        if (axi_aw_valid_o && axi_aw_ready_i) begin
          idx = axi_q.pop_front();
          compare_txn(idx, "AW", axi_aw_addr_o, 32'(axi_aw_len_o), 32'(axi_aw_size_o), 32'd0);
        end
        if (pop) begin
          idx = lsu_q.pop_front();
          compare_txn(idx, "LSU", lsu_addr_o, 32'(lsu_len_o), 32'(lsu_size_o),
                      32'(lsu_is_load_o));
        end
        queued    = queued + int'(handshake) - int'(pop);
        ar_wait   = axi_ar_valid_o && !axi_ar_ready_i;
        aw_wait   = axi_aw_valid_o && !axi_aw_ready_i;
        wait_addr = axi_ar_valid_o ? axi_ar_addr_o : axi_aw_addr_o;
        wait_len  = axi_ar_valid_o ? 32'(axi_ar_len_o) : 32'(axi_aw_len_o);
        wait_size = axi_ar_valid_o ? 32'(axi_ar_size_o) : 32'(axi_aw_size_o);
      end
    end
  end

  initial begin
    seed           = 35718;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_access_i   = addrgen_pkg::ACC_UNIT;
    req_is_load_i  = 1'b0;
    req_addr_i     = '0;
    req_len_i      = '0;
    req_vew_i      = addrgen_pkg::EW8;
    req_stride_i   = '0;
    axi_ar_ready_i = 1'b0;
    axi_aw_ready_i = 1'b0;
    lsu_ready_i    = 1'b0;
    num_reqs       = 0;
    num_txns       = 0;
    trace_lines    = 0;
    queued         = 0;
    head_ld        = -1;
    ar_wait        = 1'b0;
    aw_wait        = 1'b0;
    wait_addr      = '0;
    wait_len       = '0;
    wait_size      = '0;
    cycles         = 0;
    limit          = 0;
    waiting_ack    = 1'b0;
    cur_name       = "reset";
    load_trace();
    limit = CyclesPerLine * trace_lines;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int r = 0; r < num_reqs; r++) begin
      run_request(r);
    end
    // Let the LSU side drain what is still queued
    while (lsu_q.size() != 0) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    if (!lsu_valid_o && !axi_ar_valid_o && !axi_aw_valid_o) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run("DUT still offers traffic after the last trace request");
    end
  end

endmodule

/* hdl/addrgen_top.sv */
//////////////////////////////
// Vector memory address generator
// Request stage, burst plan, AXI issue and command queue
//////////////////////////////

`timescale 1ns/100ps

module addrgen_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer
  input  logic                 req_valid_i,
  input  addrgen_pkg::access_e req_access_i,
  input  logic                 req_is_load_i,
  input  addrgen_pkg::addr_t   req_addr_i,
  input  addrgen_pkg::vlen_t   req_len_i,
  input  addrgen_pkg::vew_e    req_vew_i,
  input  addrgen_pkg::stride_t req_stride_i,
  output logic                 ack_o,
  output logic                 error_o,
  // AR channel
  output logic                 axi_ar_valid_o,
  input  logic                 axi_ar_ready_i,
  output addrgen_pkg::addr_t   axi_ar_addr_o,
  output addrgen_pkg::axlen_t  axi_ar_len_o,
  output addrgen_pkg::axsize_t axi_ar_size_o,
  // AW channel
  output logic                 axi_aw_valid_o,
  input  logic                 axi_aw_ready_i,
  output addrgen_pkg::addr_t   axi_aw_addr_o,
  output addrgen_pkg::axlen_t  axi_aw_len_o,
  output addrgen_pkg::axsize_t axi_aw_size_o,
  // Load/store unit commands
  output logic                 lsu_valid_o,
  input  logic                 lsu_ready_i,
  output addrgen_pkg::addr_t   lsu_addr_o,
  output addrgen_pkg::axlen_t  lsu_len_o,
  output addrgen_pkg::axsize_t lsu_size_o,
  output logic                 lsu_is_load_o
);

  // Request stage to burst plan
  logic                 start;
  logic                 done;
  addrgen_pkg::access_e op_access;
  logic                 op_is_load;
  addrgen_pkg::addr_t   op_addr;
  addrgen_pkg::vlen_t   op_len;
  addrgen_pkg::vew_e    op_vew;
  addrgen_pkg::stride_t op_stride;

  // Burst plan to issue stage
  logic                 cmd_valid;
  logic                 cmd_taken;
  addrgen_pkg::addr_t   cmd_addr;
  addrgen_pkg::axlen_t  cmd_len;
  addrgen_pkg::axsize_t cmd_size;
  logic                 cmd_is_load;

  // Issue stage and command queue
  logic                 push;
  logic                 q_full;
  logic                 q_empty;
  logic                 q_head_is_load;

  addrgen_req_stage i_req_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_access_i  (req_access_i),
    .req_is_load_i (req_is_load_i),
    .req_addr_i    (req_addr_i),
    .req_len_i     (req_len_i),
    .req_vew_i     (req_vew_i),
    .req_stride_i  (req_stride_i),
    .done_i        (done),
    .ack_o         (ack_o),
    .error_o       (error_o),
    .start_o       (start),
    .access_o      (op_access),
    .is_load_o     (op_is_load),
    .addr_o        (op_addr),
    .len_o         (op_len),
    .vew_o         (op_vew),
    .stride_o      (op_stride)
  );

  addrgen_burst_plan i_burst_plan (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start),
    .access_i      (op_access),
    .is_load_i     (op_is_load),
    .addr_i        (op_addr),
    .len_i         (op_len),
    .vew_i         (op_vew),
    .stride_i      (op_stride),
    .cmd_taken_i   (cmd_taken),
    .cmd_valid_o   (cmd_valid),
    .cmd_addr_o    (cmd_addr),
    .cmd_len_o     (cmd_len),
    .cmd_size_o    (cmd_size),
    .cmd_is_load_o (cmd_is_load),
    .done_o        (done)
  );

  addrgen_axi_issue i_axi_issue (
    .cmd_valid_i    (cmd_valid),
    .cmd_addr_i     (cmd_addr),
    .cmd_len_i      (cmd_len),
    .cmd_size_i     (cmd_size),
    .cmd_is_load_i  (cmd_is_load),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_aw_ready_i (axi_aw_ready_i),
    .full_i         (q_full),
    .empty_i        (q_empty),
    .head_is_load_i (q_head_is_load),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_addr_o  (axi_ar_addr_o),
    .axi_ar_len_o   (axi_ar_len_o),
    .axi_ar_size_o  (axi_ar_size_o),
    .axi_aw_valid_o (axi_aw_valid_o),
    .axi_aw_addr_o  (axi_aw_addr_o),
    .axi_aw_len_o   (axi_aw_len_o),
    .axi_aw_size_o  (axi_aw_size_o),
    .cmd_taken_o    (cmd_taken),
    .push_o         (push)
  );

  // Queue copies exactly what went out on AR or AW
  addrgen_cmd_queue i_cmd_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .addr_i         (cmd_addr),
    .len_i          (cmd_len),
    .size_i         (cmd_size),
    .is_load_i      (cmd_is_load),
    .full_o         (q_full),
    .empty_o        (q_empty),
    .head_is_load_o (q_head_is_load),
    .lsu_ready_i    (lsu_ready_i),
    .lsu_valid_o    (lsu_valid_o),
    .lsu_addr_o     (lsu_addr_o),
    .lsu_len_o      (lsu_len_o),
    .lsu_size_o     (lsu_size_o),
    .lsu_is_load_o  (lsu_is_load_o)
  );

endmodule

/* hdl/addrgen_cmd_queue.sv */
//////////////////////////////
// Command queue
// Small FIFO of issued transactions for the load/store units
//////////////////////////////

`timescale 1ns/100ps

module addrgen_cmd_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Write side from the issue stage
  input  logic                 push_i,
  input  addrgen_pkg::addr_t   addr_i,
  input  addrgen_pkg::axlen_t  len_i,
  input  addrgen_pkg::axsize_t size_i,
  input  logic                 is_load_i,
  // Status back to the issue stage
  output logic                 full_o,
  output logic                 empty_o,
  output logic                 head_is_load_o,
  // Read side towards the load/store units
  input  logic                 lsu_ready_i,
  output logic                 lsu_valid_o,
  output addrgen_pkg::addr_t   lsu_addr_o,
  output addrgen_pkg::axlen_t  lsu_len_o,
  output addrgen_pkg::axsize_t lsu_size_o,
  output logic                 lsu_is_load_o
);

  localparam int unsigned PtrW = $clog2(addrgen_pkg::QueueDepth);
  localparam int unsigned CntW = $clog2(addrgen_pkg::QueueDepth + 1);

  // Entry storage
  addrgen_pkg::addr_t   addr_mem    [addrgen_pkg::QueueDepth];
  addrgen_pkg::axlen_t  len_mem     [addrgen_pkg::QueueDepth];
  addrgen_pkg::axsize_t size_mem    [addrgen_pkg::QueueDepth];
  logic                 is_load_mem [addrgen_pkg::QueueDepth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  assign full_o  = (count_q == CntW'(addrgen_pkg::QueueDepth));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  // Pop only a valid head
  assign do_pop  = lsu_ready_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + PtrW'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PtrW'(1);
      end
      // Simultaneous push and pop keep the count
      if (do_push && !do_pop) begin
        count_q <= count_q + CntW'(1);
      end else if (do_pop && !do_push) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      addr_mem[wr_ptr_q]    <= addr_i;
      len_mem[wr_ptr_q]     <= len_i;
      size_mem[wr_ptr_q]    <= size_i;
      is_load_mem[wr_ptr_q] <= is_load_i;
    end
  end

  // Head entry
  assign lsu_valid_o    = !empty_o;
  assign lsu_addr_o     = addr_mem[rd_ptr_q];
  assign lsu_len_o      = len_mem[rd_ptr_q];
  assign lsu_size_o     = size_mem[rd_ptr_q];
  assign lsu_is_load_o  = is_load_mem[rd_ptr_q];
  assign head_is_load_o = is_load_mem[rd_ptr_q];

endmodule

/* hdl/addrgen_axi_issue.sv */
//////////////////////////////
// AXI issue stage
// Steers each transaction to AR or AW under the queue
// ordering rules and pushes it to the command queue
//////////////////////////////

`timescale 1ns/100ps

module addrgen_axi_issue (
  // Transaction from the burst plan
  input  logic                 cmd_valid_i,
  input  addrgen_pkg::addr_t   cmd_addr_i,
  input  addrgen_pkg::axlen_t  cmd_len_i,
  input  addrgen_pkg::axsize_t cmd_size_i,
  input  logic                 cmd_is_load_i,
  // Channel readies
  input  logic                 axi_ar_ready_i,
  input  logic                 axi_aw_ready_i,
  // Command queue status
  input  logic                 full_i,
  input  logic                 empty_i,
  input  logic                 head_is_load_i,
  // AR channel
  output logic                 axi_ar_valid_o,
  output addrgen_pkg::addr_t   axi_ar_addr_o,
  output addrgen_pkg::axlen_t  axi_ar_len_o,
  output addrgen_pkg::axsize_t axi_ar_size_o,
  // AW channel
  output logic                 axi_aw_valid_o,
  output addrgen_pkg::addr_t   axi_aw_addr_o,
  output addrgen_pkg::axlen_t  axi_aw_len_o,
  output addrgen_pkg::axsize_t axi_aw_size_o,
  // Handshake results
  output logic                 cmd_taken_o,
  output logic                 push_o
);

  logic order_ok;
  logic issue;
  logic ar_hs;
  logic aw_hs;

  // Queue has room, and any queued commands go the same direction.
  // Keeps load and store responses from interleaving at the LSUs
  assign order_ok = !full_i && (empty_i || (head_is_load_i == cmd_is_load_i));
  assign issue    = cmd_valid_i && order_ok;

  //////////////////////////////
  // Channel steering
  //////////////////////////////

  assign axi_ar_valid_o = issue && cmd_is_load_i;
  assign axi_aw_valid_o = issue && !cmd_is_load_i;

  // Fields stay put while the plan holds the command
  assign axi_ar_addr_o  = cmd_addr_i;
  assign axi_ar_len_o   = cmd_len_i;
  assign axi_ar_size_o  = cmd_size_i;
  assign axi_aw_addr_o  = cmd_addr_i;
  assign axi_aw_len_o   = cmd_len_i;
  assign axi_aw_size_o  = cmd_size_i;

  // Handshake on whichever channel is active
  assign ar_hs = axi_ar_valid_o && axi_ar_ready_i;
  assign aw_hs = axi_aw_valid_o && axi_aw_ready_i;

  // Plan advances and the queue records the command together
  assign cmd_taken_o = ar_hs || aw_hs;
  assign push_o      = ar_hs || aw_hs;

endmodule

/* hdl/addrgen_burst_plan.sv */
//////////////////////////////
// Burst plan
// Tracks the remaining elements and the current address,
// and sizes each transaction within the burst and page limits
//////////////////////////////

`timescale 1ns/100ps

module addrgen_burst_plan (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request from the request stage
  input  logic                 start_i,
  input  addrgen_pkg::access_e access_i,
  input  logic                 is_load_i,
  input  addrgen_pkg::addr_t   addr_i,
  input  addrgen_pkg::vlen_t   len_i,
  input  addrgen_pkg::vew_e    vew_i,
  input  addrgen_pkg::stride_t stride_i,
  // Handshake with the issue stage
  input  logic                 cmd_taken_i,
  output logic                 cmd_valid_o,
  output addrgen_pkg::addr_t   cmd_addr_o,
  output addrgen_pkg::axlen_t  cmd_len_o,
  output addrgen_pkg::axsize_t cmd_size_o,
  output logic                 cmd_is_load_o,
  output logic                 done_o
);

  addrgen_pkg::plan_state_e state_q;
  logic                     done_q;

  // Operation state
  addrgen_pkg::access_e access_q;
  logic                 is_load_q;
  addrgen_pkg::addr_t   cur_addr_q;
  addrgen_pkg::vlen_t   len_rem_q;
  addrgen_pkg::vew_e    vew_q;
  addrgen_pkg::stride_t stride_q;

  // Current transaction
  addrgen_pkg::addr_t   burst_end_q;
  addrgen_pkg::axlen_t  cmd_len_q;
  addrgen_pkg::axsize_t cmd_size_q;

  addrgen_pkg::addr_t   aligned_start;
  addrgen_pkg::addr_t   run_end;
  addrgen_pkg::addr_t   max_end;
  addrgen_pkg::addr_t   page_end;
  addrgen_pkg::addr_t   burst_end;
  addrgen_pkg::addr_t   consumed;
  addrgen_pkg::addr_t   next_addr;
  addrgen_pkg::vlen_t   next_len;

  //////////////////////////////
  // Unit-stride boundaries
  //////////////////////////////

  always_comb begin
    aligned_start = cur_addr_q & ~addrgen_pkg::addr_t'(addrgen_pkg::BusBytes - 1);
    // Last byte of the run, rounded up to the end of its beat
    run_end = (cur_addr_q + (addrgen_pkg::addr_t'(len_rem_q) << vew_q) - addrgen_pkg::addr_t'(1))
              | addrgen_pkg::addr_t'(addrgen_pkg::BusBytes - 1);
    max_end = aligned_start
              + addrgen_pkg::addr_t'(addrgen_pkg::MaxBeats * addrgen_pkg::BusBytes - 1);
    page_end = cur_addr_q | addrgen_pkg::addr_t'((1 << addrgen_pkg::PageBits) - 1);
    // Smallest of the three bounds
    burst_end = run_end;
    if (max_end < burst_end) begin
      burst_end = max_end;
    end
    if (page_end < burst_end) begin
      burst_end = page_end;
    end
  end

  //////////////////////////////
  // Advance on each issue
  //////////////////////////////

  always_comb begin
    consumed = ((burst_end_q - cur_addr_q) + addrgen_pkg::addr_t'(1)) >> vew_q;
    if (access_q == addrgen_pkg::ACC_STRIDED) begin
      next_addr = cur_addr_q + stride_q;
      next_len  = len_rem_q - addrgen_pkg::vlen_t'(1);
    end else begin
      next_addr = burst_end_q + addrgen_pkg::addr_t'(1);
      // Count saturates at zero for a partly used last beat
      if (addrgen_pkg::addr_t'(len_rem_q) > consumed) begin
        next_len = len_rem_q - addrgen_pkg::vlen_t'(consumed);
      end else begin
        next_len = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= addrgen_pkg::PLAN_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        addrgen_pkg::PLAN_IDLE: begin
          if (start_i) begin
            state_q <= addrgen_pkg::PLAN_CALC;
          end
        end
        addrgen_pkg::PLAN_CALC: begin
          state_q <= addrgen_pkg::PLAN_READY;
        end
        default: begin
          if (cmd_taken_i) begin
            // Last transaction ends the operation
            done_q  <= (next_len == '0);
            state_q <= (next_len == '0) ? addrgen_pkg::PLAN_IDLE : addrgen_pkg::PLAN_CALC;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == addrgen_pkg::PLAN_IDLE && start_i) begin
      access_q   <= access_i;
      is_load_q  <= is_load_i;
      cur_addr_q <= addr_i;
      len_rem_q  <= len_i;
      vew_q      <= vew_i;
      stride_q   <= stride_i;
    end else if (state_q == addrgen_pkg::PLAN_CALC) begin
      burst_end_q <= burst_end;
      if (access_q == addrgen_pkg::ACC_STRIDED) begin
        // Single beat of one element
        cmd_len_q  <= '0;
        cmd_size_q <= addrgen_pkg::axsize_t'(vew_q);
      end else begin
        cmd_len_q  <= addrgen_pkg::axlen_t'((burst_end - aligned_start) >> addrgen_pkg::BusBytesLog);
        cmd_size_q <= addrgen_pkg::axsize_t'(addrgen_pkg::BusBytesLog);
      end
    end else if (state_q == addrgen_pkg::PLAN_READY && cmd_taken_i) begin
      cur_addr_q <= next_addr;
      len_rem_q  <= next_len;
    end
  end

  assign cmd_valid_o   = (state_q == addrgen_pkg::PLAN_READY);
  assign cmd_addr_o    = cur_addr_q;
  assign cmd_len_o     = cmd_len_q;
  assign cmd_size_o    = cmd_size_q;
  assign cmd_is_load_o = is_load_q;
  assign done_o        = done_q;

endmodule

/* hdl/addrgen_req_stage.sv */
//////////////////////////////
// Request stage
// Samples one sequencer request, checks element alignment,
// starts the burst plan and acknowledges when it is done
//////////////////////////////

`timescale 1ns/100ps

module addrgen_req_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer request
  input  logic                 req_valid_i,
  input  addrgen_pkg::access_e req_access_i,
  input  logic                 req_is_load_i,
  input  addrgen_pkg::addr_t   req_addr_i,
  input  addrgen_pkg::vlen_t   req_len_i,
  input  addrgen_pkg::vew_e    req_vew_i,
  input  addrgen_pkg::stride_t req_stride_i,
  // Completion from the burst plan
  input  logic                 done_i,
  // Sequencer response
  output logic                 ack_o,
  output logic                 error_o,
  // Registered request towards the burst plan
  output logic                 start_o,
  output addrgen_pkg::access_e access_o,
  output logic                 is_load_o,
  output addrgen_pkg::addr_t   addr_o,
  output addrgen_pkg::vlen_t   len_o,
  output addrgen_pkg::vew_e    vew_o,
  output addrgen_pkg::stride_t stride_o
);

  addrgen_pkg::req_state_e state_q;
  logic                    err_q;
  logic                    misalign;

  // Request fields, held for the whole operation
  addrgen_pkg::access_e access_q;
  logic                 is_load_q;
  addrgen_pkg::addr_t   addr_q;
  addrgen_pkg::vlen_t   len_q;
  addrgen_pkg::vew_e    vew_q;
  addrgen_pkg::stride_t stride_q;

  // Base address must be a multiple of the element size
  assign misalign = |(addr_q & ((addrgen_pkg::addr_t'(1) << vew_q) - addrgen_pkg::addr_t'(1)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= addrgen_pkg::REQ_IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        addrgen_pkg::REQ_IDLE: begin
          if (req_valid_i) begin
            state_q <= addrgen_pkg::REQ_CHECK;
          end
        end
        addrgen_pkg::REQ_CHECK: begin
          // Rejected requests go straight to the ack
          err_q   <= misalign;
          state_q <= misalign ? addrgen_pkg::REQ_ACK : addrgen_pkg::REQ_BUSY;
        end
        addrgen_pkg::REQ_BUSY: begin
          if (done_i) begin
            state_q <= addrgen_pkg::REQ_ACK;
          end
        end
        default: begin
          state_q <= addrgen_pkg::REQ_IDLE;
        end
      endcase
    end
  end

  // Capture the request while idle
  always_ff @(posedge clk_i) begin
    if (state_q == addrgen_pkg::REQ_IDLE && req_valid_i) begin
      access_q  <= req_access_i;
      is_load_q <= req_is_load_i;
      addr_q    <= req_addr_i;
      len_q     <= req_len_i;
      vew_q     <= req_vew_i;
      stride_q  <= req_stride_i;
    end
  end

  // One-cycle start once the check passes
  assign start_o   = (state_q == addrgen_pkg::REQ_CHECK) && !misalign;
  assign ack_o     = (state_q == addrgen_pkg::REQ_ACK);
  assign error_o   = (state_q == addrgen_pkg::REQ_ACK) && err_q;

  assign access_o  = access_q;
  assign is_load_o = is_load_q;
  assign addr_o    = addr_q;
  assign len_o     = len_q;
  assign vew_o     = vew_q;
  assign stride_o  = stride_q;

endmodule

/* hdl/addrgen_pkg.sv */
//////////////////////////////
// Vector address generator shared definitions
// Widths, types, bus constants and FSM encodings
//////////////////////////////

package addrgen_pkg;

  //////////////////////////////
  // Bus and memory geometry
  //////////////////////////////

  localparam int unsigned AddrWidth   = 32;
  // Data beat is 64 bits wide
  localparam int unsigned BusBytes    = 8;
  localparam int unsigned BusBytesLog = 3;
  // AXI INCR limit
  localparam int unsigned MaxBeats    = 256;
  // 4 KiB page offset
  localparam int unsigned PageBits    = 12;
  // Command queue entries
  localparam int unsigned QueueDepth  = 4;

  //////////////////////////////
  // Vector types
  //////////////////////////////

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [15:0]          vlen_t;
  // Two's complement byte stride
  typedef logic [AddrWidth-1:0] stride_t;
  // Beats minus one
  typedef logic [7:0]           axlen_t;
  typedef logic [2:0]           axsize_t;

  // Value is log2 of the element byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic {
    ACC_UNIT    = 1'b0,
    ACC_STRIDED = 1'b1
  } access_e;

  //////////////////////////////
  // FSM encodings
  //////////////////////////////

  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_CHECK,
    REQ_BUSY,
    REQ_ACK
  } req_state_e;

  typedef enum logic [1:0] {
    PLAN_IDLE,
    PLAN_CALC,
    PLAN_READY
  } plan_state_e;

endpackage
